// File: run.sh
#!/usr/bin/env bash
# Build and run the SD data transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module sdtx_frame_tb --Mdir "$OBJ" -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Raised error limit lets the testbench see checker failures and stop itself
"./$OBJ/Vsdtx_frame_tb" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qxF '** PASS **' "$LOG" && [ "$sim_status" -eq 0 ]; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, exit status $sim_status, see $LOG"
exit 1

// File: tb.f
verilog/sdtx_pkg.sv
verilog/sdtx_framer.sv
verilog/sdtx_crc.sv
verilog/sdtx_serializer.sv
verilog/sdtx_frame.sv
testbench/sdtx_frame_chk.sv
testbench/sdtx_frame_tb.sv

// File: testbench/sdtx_frame_chk.sv
// Timing rules only, one clock with synchronous reset; pin values are left to the testbench model
module sdtx_frame_chk
	import sdtx_pkg::*;
(
	input logic            i_clk,
	input logic            i_reset,
	input logic            i_ckstb,
	input logic            i_s_ready,
	input logic            i_tx_valid,
	input logic [PINS-1:0] i_tx_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far
	int fail_cnt = 0;

	// Pins come out of reset idle
	valid_after_reset: assert property (@(posedge i_clk) $past(i_reset) |-> !i_tx_valid)
	else
	begin
		$error("o_tx_valid high in the cycle after reset");
		fail_cnt++;
	end

	// Beats only move on a card clock
	ready_on_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		i_s_ready |-> i_ckstb)
	else
	begin
		$error("o_s_ready high without i_ckstb");
		fail_cnt++;
	end

	// Pins hold between strobes
	data_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(!$past(i_ckstb) && !$past(i_reset)) |-> $stable(i_tx_data))
	else
	begin
		$error("o_tx_data changed without a strobe");
		fail_cnt++;
	end

endmodule

// File: testbench/sdtx_frame_tb.sv
// Bit-level pin model; stalls fall only between strobes since the framer cannot wait for a beat
module sdtx_frame_tb
	import sdtx_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NROWS       = 8;
	localparam int BLOCK_LIMIT = 4000;

	// One table row
	// exp_bits is the pin strobe count of the whole block
	typedef struct packed
	{
		bus_width_e width;
		logic [2:0] nwords;
		logic       stall;
		logic [4:0] en_hold;
		logic [7:0] exp_bits;
	} block_row_t;

	logic            i_clk;
	logic            i_reset;
	logic            i_en;
	logic            i_ckstb;
	bus_width_e      i_cfg_width;
	logic            i_s_valid;
	s_beat_t         i_s_beat;
	logic            o_s_ready;
	logic            o_tx_valid;
	logic [PINS-1:0] o_tx_data;

	block_row_t        rows [NROWS];
	logic [WORD_W-1:0] words [4];
	// Expected pin values, one per strobe while valid
	logic [PINS-1:0]   exp_q [$];
	// Values seen at the last rising edge
	logic              stb_q;
	logic              acc_q;
	logic              rdy_q;
	int                gap_cnt;
	int                stall_cnt;
	int                pins_seen;

	sdtx_frame #(
		.CRC_POLY (16'h1021)
	) dut_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_en        (i_en),
		.i_ckstb     (i_ckstb),
		.i_cfg_width (i_cfg_width),
		.i_s_valid   (i_s_valid),
		.i_s_beat    (i_s_beat),
		.o_s_ready   (o_s_ready),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

	bind sdtx_frame sdtx_frame_chk chk_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_ckstb    (i_ckstb),
		.i_s_ready  (o_s_ready),
		.i_tx_valid (o_tx_valid),
		.i_tx_data  (o_tx_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#20 i_clk = ~i_clk;
	end

	// Strobe and handshake as the DUT saw them
	always @(posedge i_clk)
	begin
		stb_q <= i_ckstb;
		acc_q <= i_s_valid && o_s_ready;
		rdy_q <= o_s_ready;
	end

	////////////////////
	// Reference model
	////////////////////

	// Advance the CRC16 by one data bit
	function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic din);
		logic fb;
		fb = crc[15] ^ din;
		crc16_bit = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
	endfunction

	// Start, data, per-lane CRC and end bit with unused pins high
	task automatic build_expected(input bus_width_e width, input int nwords);
		logic [15:0] crc [PINS];
		exp_q.delete();
		for (int ln = 0; ln < PINS; ln++)
			crc[ln] = 16'h0000;
		if (width == W4)
		begin
			exp_q.push_back(4'b0000);
			for (int w = 0; w < nwords; w++)
				for (int k = 7; k >= 0; k--)
				begin
					// Pin ln carries bit 4k+ln
					exp_q.push_back(words[w][4*k +: 4]);
					for (int ln = 0; ln < PINS; ln++)
						crc[ln] = crc16_bit(crc[ln], words[w][4*k+ln]);
				end
			for (int j = 15; j >= 0; j--)
				exp_q.push_back({crc[3][j], crc[2][j], crc[1][j], crc[0][j]});
		end
		else
		begin
			exp_q.push_back(4'b1110);
			for (int w = 0; w < nwords; w++)
				for (int b = 31; b >= 0; b--)
				begin
					exp_q.push_back({3'b111, words[w][b]});
					crc[0] = crc16_bit(crc[0], words[w][b]);
				end
			for (int j = 15; j >= 0; j--)
				exp_q.push_back({3'b111, crc[0][j]});
		end
		exp_q.push_back(4'b1111);
	endtask

	////////////////////
	// Checks
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [3:0] got, input logic [3:0] exp);
		assert (got == exp)
		else
			stop_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	// Compare one pin value per strobe inside the block
	task automatic check_cycle();
		logic [PINS-1:0] exp;
		assert (dut_i.chk_i.fail_cnt == 0)
		else
			stop_run("a protocol assertion in the checker failed");
		if (stb_q && o_tx_valid)
		begin
			assert (exp_q.size() > 0)
			else
				stop_run("pins still valid after the expected end bit");
			exp = exp_q.pop_front();
			pins_seen++;
			check_value("o_tx_data", o_tx_data, exp);
		end
	endtask

	// Strobe spacing of 1 to 4 cycles
	task automatic drive_strobe();
		if (gap_cnt <= 1)
		begin
			i_ckstb = 1'b1;
			gap_cnt = $urandom_range(4, 1);
		end
		else
		begin
			i_ckstb = 1'b0;
			gap_cnt--;
		end
	endtask

	// Sample outputs first, then drive on the falling edge
	task automatic next_cycle();
		@(negedge i_clk);
		check_cycle();
		drive_strobe();
	endtask

	////////////////////
	// Block driver
	////////////////////

	task automatic run_block(input int r);
		block_row_t row;
		bus_width_e next_width;
		int         idx;
		int         cyc;
		logic       seen_valid;
		row = rows[r];
		next_width = (r + 1 < NROWS) ? rows[r+1].width : ((row.width == W4) ? W1 : W4);
		for (int w = 0; w < 4; w++)
			words[w] = $urandom();
		build_expected(row.width, int'(row.nwords));
		pins_seen = 0;
		i_s_beat.data = words[0];
		i_s_beat.last = (row.nwords == 3'd1);
		i_s_valid = 1'b1;
		// Beat waits while the block is held off
		i_en = (row.en_hold == 5'd0);
		for (int c = 0; c < int'(row.en_hold); c++)
		begin
			next_cycle();
			check_value("o_s_ready", {3'b000, rdy_q}, 4'h0);
			check_value("o_tx_valid", {3'b000, o_tx_valid}, 4'h0);
		end
		i_en = 1'b1;
		idx = 0;
		cyc = 0;
		stall_cnt = 0;
		seen_valid = 1'b0;
		while (!(idx == int'(row.nwords) && seen_valid && !o_tx_valid))
		begin
			assert (cyc < BLOCK_LIMIT)
			else
				stop_run("timeout waiting for the block to finish");
			cyc++;
			next_cycle();
			if (o_tx_valid)
				seen_valid = 1'b1;
			if (acc_q)
			begin
				// Width for the next block changes mid-block
				if (idx == 0)
					i_cfg_width = next_width;
				idx++;
				if (row.stall)
					stall_cnt = $urandom_range(3, 1);
				if (idx < int'(row.nwords))
				begin
					i_s_beat.data = words[idx];
					i_s_beat.last = (idx == int'(row.nwords) - 1);
				end
			end
			// Stall only in cycles without a strobe
			if (idx >= int'(row.nwords))
				i_s_valid = 1'b0;
			else if (stall_cnt > 0 && !i_ckstb)
			begin
				i_s_valid = 1'b0;
				stall_cnt--;
			end
			else
			begin
				i_s_valid = 1'b1;
				stall_cnt = 0;
			end
		end
		assert (pins_seen == int'(row.exp_bits) && exp_q.size() == 0)
		else
			stop_run($sformatf("FAIL %0t pin strobe count got %0d expected %0d",
				$time, pins_seen, row.exp_bits));
		check_value("o_tx_data", o_tx_data, 4'hf);
	endtask

	initial
	begin
		void'($urandom(32'h52f4));
		i_reset = 1'b1;
		i_en = 1'b0;
		i_ckstb = 1'b0;
		i_s_valid = 1'b0;
		i_s_beat = '0;
		gap_cnt = 1;
		stall_cnt = 0;
		pins_seen = 0;
		// Width, words, stall, enable hold, strobes per block
		rows[0] = '{W1, 3'd1, 1'b0, 5'd0, 8'd50};
		rows[1] = '{W1, 3'd3, 1'b0, 5'd0, 8'd114};
		rows[2] = '{W4, 3'd2, 1'b0, 5'd0, 8'd34};
		rows[3] = '{W4, 3'd4, 1'b1, 5'd0, 8'd50};
		rows[4] = '{W1, 3'd2, 1'b1, 5'd0, 8'd82};
		rows[5] = '{W4, 3'd3, 1'b0, 5'd12, 8'd42};
		rows[6] = '{W1, 3'd4, 1'b1, 5'd6, 8'd146};
		rows[7] = '{W4, 3'd1, 1'b1, 5'd0, 8'd26};
		i_cfg_width = rows[0].width;
		repeat (8)
			@(negedge i_clk);
		i_reset = 1'b0;
		// Idle pins before any block
		for (int c = 0; c < 10; c++)
		begin
			next_cycle();
			check_value("o_tx_valid", {3'b000, o_tx_valid}, 4'h0);
			check_value("o_s_ready", {3'b000, rdy_q}, 4'h0);
			check_value("o_tx_data", o_tx_data, 4'hf);
		end
		for (int r = 0; r < NROWS; r++)
			run_block(r);
		if (exp_q.size() == 0 && dut_i.chk_i.fail_cnt == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			stop_run("checks left open at the end of the run");
	end

endmodule

// File: verilog/sdtx_crc.sv
// CRC starts from zero; between blocks the register is emptied by shifting, or cleared when idle
module sdtx_crc
	import sdtx_pkg::*;
#(
	parameter logic [NCRC-1:0] CRC_POLY = 16'h1021
)
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_en,
	input  logic               i_tx_valid,
	input  bus_width_e         i_width,
	input  logic               i_accept,
	input  logic               i_crc_shift,
	input  logic [WORD_W-1:0]  i_data,
	output logic [WORD_W-1:0]  o_crc_word
);

	// Bits each lane takes from one word in 4-lane mode
	localparam int LANE_BITS = WORD_W / PINS;

	// Lane ln, CRC bit b sits at b*PINS+ln
	logic [PINS*NCRC-1:0]           crc_reg;
	logic [PINS*NCRC-1:0]           nxt_crc4;
	logic [NCRC-1:0]                nxt_crc1;
	logic [PINS-1:0][NCRC-1:0]      lane_crc;
	logic [PINS-1:0][NCRC-1:0]      lane_nxt;
	logic [PINS-1:0][LANE_BITS-1:0] lane_bits;

	// Run the top nbits of bits through the CRC, MSB first
	function automatic logic [NCRC-1:0] crc_apply(
		input logic [NCRC-1:0]   prior,
		input logic [WORD_W-1:0] bits,
		input int                nbits
	);
		logic [NCRC-1:0] fill;
		logic            fb;
		fill = prior;
		for (int k = WORD_W - 1; k >= 0; k--)
		begin
			if (k < nbits)
			begin
				fb   = fill[NCRC-1] ^ bits[k];
				fill = {fill[NCRC-2:0], 1'b0};
				if (fb)
					fill = fill ^ CRC_POLY;
			end
		end
		return fill;
	endfunction

	////////////////////
	// Next CRC values
	////////////////////

	always_comb
	begin
		for (int ln = 0; ln < PINS; ln++)
		begin
			// Sort out one lane's CRC and its data bits
			for (int b = 0; b < NCRC; b++)
				lane_crc[ln][b] = crc_reg[b*PINS+ln];
			for (int b = 0; b < LANE_BITS; b++)
				lane_bits[ln][b] = i_data[b*PINS+ln];
			lane_nxt[ln] = crc_apply(lane_crc[ln],
				{{(WORD_W-LANE_BITS){1'b0}}, lane_bits[ln]}, LANE_BITS);
			// Put it back in pin order
			for (int b = 0; b < NCRC; b++)
				nxt_crc4[b*PINS+ln] = lane_nxt[ln][b];
		end
	end

	// DAT0 alone takes the whole word
	assign nxt_crc1 = crc_apply(crc_reg[PINS*NCRC-1 -: NCRC], i_data, WORD_W);

	////////////////////
	// CRC register
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || (!i_en && !i_tx_valid))
			crc_reg <= '0;
		else if (i_accept)
		begin
			if (i_width == W4)
				crc_reg <= nxt_crc4;
			else
				crc_reg <= {nxt_crc1, {((PINS-1)*NCRC){1'b0}}};
		end
		else if (i_crc_shift)
			// Zeros behind, so a drained register is ready for the next block
			crc_reg <= {crc_reg[PINS*NCRC-WORD_W-1:0], {WORD_W{1'b0}}};
	end

	assign o_crc_word = crc_reg[PINS*NCRC-1 -: WORD_W];

endmodule

// File: verilog/sdtx_frame.sv
// SD data block transmitter, 1 or 4 lanes, one data bit per card clock, single block per start
module sdtx_frame
	import sdtx_pkg::*;
#(
	parameter logic [NCRC-1:0] CRC_POLY = 16'h1021
)
(
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_en,
	input  logic             i_ckstb,
	input  bus_width_e       i_cfg_width,
	input  logic             i_s_valid,
	input  s_beat_t          i_s_beat,
	output logic             o_s_ready,
	output logic             o_tx_valid,
	output logic [PINS-1:0]  o_tx_data
);

	logic              start;
	logic              accept;
	logic              crc_shift;
	logic              pre_valid;
	logic              ser_empty;
	logic [WORD_W-1:0] crc_word;
	bus_width_e        width;
	pre_word_t         pre;

	////////////////////
	// Block control
	////////////////////

	sdtx_framer framer_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_en        (i_en),
		.i_ckstb     (i_ckstb),
		.i_cfg_width (i_cfg_width),
		.i_s_valid   (i_s_valid),
		.i_s_beat    (i_s_beat),
		.i_tx_valid  (o_tx_valid),
		.i_ser_empty (ser_empty),
		.i_crc_word  (crc_word),
		.o_s_ready   (o_s_ready),
		.o_start     (start),
		.o_accept    (accept),
		.o_crc_shift (crc_shift),
		.o_width     (width),
		.o_pre_valid (pre_valid),
		.o_pre       (pre)
	);

	// Per-lane CRC over accepted words
	sdtx_crc #(
		.CRC_POLY (CRC_POLY)
	) crc_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_en        (i_en),
		.i_tx_valid  (o_tx_valid),
		.i_width     (width),
		.i_accept    (accept),
		.i_crc_shift (crc_shift),
		.i_data      (i_s_beat.data),
		.o_crc_word  (crc_word)
	);

	////////////////////
	// Pins
	////////////////////

	sdtx_serializer ser_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_ckstb     (i_ckstb),
		.i_start     (start),
		.i_width     (width),
		.i_pre_valid (pre_valid),
		.i_pre       (pre),
		.o_empty     (ser_empty),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

endmodule

// File: verilog/sdtx_framer.sv
// Source must present the next beat by the drain strobe of the current word or the block ends
module sdtx_framer
	import sdtx_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_en,
	input  logic               i_ckstb,
	input  bus_width_e         i_cfg_width,
	input  logic               i_s_valid,
	input  s_beat_t            i_s_beat,
	input  logic               i_tx_valid,
	input  logic               i_ser_empty,
	input  logic [WORD_W-1:0]  i_crc_word,
	output logic               o_s_ready,
	output logic               o_start,
	output logic               o_accept,
	output logic               o_crc_shift,
	output bus_width_e         o_width,
	output logic               o_pre_valid,
	output pre_word_t          o_pre
);

	frame_state_e state;
	bus_width_e   width_q;
	// Set while a second CRC word is still owed (4-lane only)
	logic         crc_left;
	// Serializer can take a word on this strobe
	logic         pre_ready;

	////////////////////
	// Width latch
	////////////////////

	// Follow the config while idle, freeze it for the whole block
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			width_q <= W1;
		else if (state == IDLE)
			width_q <= i_cfg_width;
	end

	// Start cycle must already see the new width
	assign o_width = (state == IDLE) ? i_cfg_width : width_q;

	////////////////////
	// Handshake
	////////////////////

	assign pre_ready = i_ckstb && i_ser_empty;

	// The only place the block start is decided
	assign o_start = i_en && i_s_valid && i_ckstb && (state == IDLE) && !i_tx_valid;

	// In IDLE, ready only when a start could happen, so no beat is dropped
	assign o_s_ready = pre_ready
		&& ((state == DATA) || ((state == IDLE) && i_en && !i_tx_valid));

	assign o_accept = i_s_valid && o_s_ready;

	// CRC word taken by the pipeline on this strobe
	assign o_crc_shift = (state == CRC) && pre_ready;

	////////////////////
	// Block FSM
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state       <= IDLE;
			o_pre_valid <= 1'b0;
			crc_left    <= 1'b0;
		end
		else
		begin
			case (state)
			IDLE:
			begin
				o_pre_valid <= 1'b0;
				crc_left    <= (o_width == W4);
				if (o_start)
				begin
					o_pre_valid <= 1'b1;
					state       <= i_s_beat.last ? CRC : DATA;
				end
			end
			DATA:
			begin
				crc_left <= (o_width == W4);
				// Word consumed; keep one ready only if a beat replaced it
				if (pre_ready)
					o_pre_valid <= o_accept;
				if (o_accept && i_s_beat.last)
					state <= CRC;
			end
			CRC:
			begin
				if (pre_ready)
				begin
					o_pre_valid <= 1'b1;
					crc_left    <= 1'b0;
					if (!crc_left)
						state <= LAST;
				end
			end
			default:
			begin
				// Serializer now sends the last CRC word and the end bit
				if (pre_ready)
					o_pre_valid <= 1'b0;
				if (!i_tx_valid)
					state <= IDLE;
			end
			endcase
		end
	end

	// Word payload for the serializer
	always_ff @(posedge i_clk)
	begin
		if (o_accept)
		begin
			o_pre.data <= i_s_beat.data;
			o_pre.half <= 1'b0;
		end
		else if (o_crc_shift)
		begin
			o_pre.data <= i_crc_word;
			// 1-lane CRC is a single 16 bit word
			o_pre.half <= (o_width == W1);
		end
	end

endmodule

// File: verilog/sdtx_pkg.sv
// Shared widths and types; the CRC width is fixed at 16 since word slicing depends on it
package sdtx_pkg;

	////////////////////
	// Widths
	////////////////////

	// CRC bits per data lane
	localparam int NCRC = 16;

	// Stream word width
	localparam int WORD_W = 32;

	// Card data pins, DAT3..DAT0
	localparam int PINS = 4;

	////////////////////
	// Encodings
	////////////////////

	// Bus width of one block
	// W1 drives DAT0 only, W4 drives DAT3..DAT0
	typedef enum logic [1:0]
	{
		W1 = 2'b00,
		W4 = 2'b01
	} bus_width_e;

	// Framer states
	// IDLE waits for a start, DATA takes stream words,
	// CRC hands the CRC words over, LAST waits for the end bit to go out
	typedef enum logic [1:0]
	{
		IDLE = 2'b00,
		DATA = 2'b01,
		CRC  = 2'b10,
		LAST = 2'b11
	} frame_state_e;

	////////////////////
	// Bundles
	////////////////////

	// One beat of the input stream
	typedef struct packed
	{
		// Payload, sent MSB first
		logic [WORD_W-1:0] data;
		// Final word of the block
		logic last;
	} s_beat_t;

	// One word from the framer to the pin serializer
	typedef struct packed
	{
		// Pin-ordered bits, top bits go out first
		logic [WORD_W-1:0] data;
		// Only the top 16 bits count, used by the 1-lane CRC word
		logic half;
	} pre_word_t;

endpackage

// File: verilog/sdtx_serializer.sv
// Pin shifter; moves only on i_ckstb, has no pin back-pressure, unused pins idle high
module sdtx_serializer
	import sdtx_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_ckstb,
	input  logic             i_start,
	input  bus_width_e       i_width,
	input  logic             i_pre_valid,
	input  pre_word_t        i_pre,
	output logic             o_empty,
	output logic             o_tx_valid,
	output logic [PINS-1:0]  o_tx_data
);

	// Bits still to come after the one on the pins
	logic [4:0]        count;
	logic [WORD_W-1:0] sreg;
	// End bit owed once the data runs out
	logic              end_pend;
	// Start bit pattern for the used pins
	logic [PINS-1:0]   start_bits;

	assign o_empty = (count == 5'd0);

	assign start_bits = (i_width == W4) ? {PINS{1'b0}} : {{(PINS-1){1'b1}}, 1'b0};

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_tx_valid <= 1'b0;
			end_pend   <= 1'b0;
			count      <= 5'd0;
			o_tx_data  <= {PINS{1'b1}};
		end
		else if (i_start)
		begin
			// Start bit goes out on this strobe
			o_tx_valid <= 1'b1;
			end_pend   <= 1'b1;
			o_tx_data  <= start_bits;
		end
		else if (i_ckstb)
		begin
			if (o_empty && i_pre_valid)
			begin
				// Fresh word, top bits straight onto the pins
				if (i_width == W4)
				begin
					count     <= 5'd7;
					o_tx_data <= i_pre.data[WORD_W-1 -: PINS];
				end
				else
				begin
					count     <= i_pre.half ? 5'd15 : 5'd31;
					o_tx_data <= {{(PINS-1){1'b1}}, i_pre.data[WORD_W-1]};
				end
			end
			else if (!o_empty)
			begin
				count <= count - 5'd1;
				if (i_width == W4)
					o_tx_data <= sreg[WORD_W-1 -: PINS];
				else
					o_tx_data <= {{(PINS-1){1'b1}}, sreg[WORD_W-1]};
			end
			else if (end_pend)
			begin
				// End bit, still inside the block
				end_pend  <= 1'b0;
				o_tx_data <= {PINS{1'b1}};
			end
			else
			begin
				o_tx_valid <= 1'b0;
				o_tx_data  <= {PINS{1'b1}};
			end
		end
	end

	////////////////////
	// Shift register
	////////////////////

	// Remaining bits of the word, ones fill behind
	always_ff @(posedge i_clk)
	begin
		if (i_ckstb && !i_start)
		begin
			if (o_empty && i_pre_valid)
			begin
				if (i_width == W4)
					sreg <= {i_pre.data[WORD_W-PINS-1:0], {PINS{1'b1}}};
				else
					sreg <= {i_pre.data[WORD_W-2:0], 1'b1};
			end
			else if (!o_empty)
			begin
				if (i_width == W4)
					sreg <= {sreg[WORD_W-PINS-1:0], {PINS{1'b1}}};
				else
					sreg <= {sreg[WORD_W-2:0], 1'b1};
			end
		end
	end

endmodule
